//--- Bender.yml
package:
  name: mesh_route_unit

sources:
  - include_dirs:
      - design
    files:
      - design/noc_pkg.sv
      - design/mesh_endp_decode.sv
      - design/xy_route_calc.sv
      - design/next_router_select.sv
      - design/route_compute_stage.sv
      - design/look_ahead_stage.sv
      - design/mesh_route_unit.sv

  - target: test
    include_dirs:
      - design
    files:
      - tests/mesh_route_checker.sv
      - tests/mesh_route_unit_tb.sv

//--- build.f
+incdir+design
design/noc_pkg.sv
design/mesh_endp_decode.sv
design/xy_route_calc.sv
design/next_router_select.sv
design/route_compute_stage.sv
design/look_ahead_stage.sv
design/mesh_route_unit.sv
tests/mesh_route_checker.sv
tests/mesh_route_unit_tb.sv

//--- design/look_ahead_stage.sv
`timescale 1ns/100ps

module look_ahead_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  noc_pkg::stage1_rec_t  rec,
    output logic                  out_valid,
    output noc_pkg::port_onehot_t destport,
    output noc_pkg::port_onehot_t lkdestport,
    output logic                  dest_err
);

    noc_pkg::mesh_coord_t  next_coord;
    logic                  is_local;
    noc_pkg::port_onehot_t next_port;
    noc_pkg::port_onehot_t lk_port;

    next_router_select u_next (
        .cur      (rec.cur),
        .port     (rec.port),
        .next     (next_coord),
        .is_local (is_local)
    );

    // same XY decision, taken at the neighbor
    xy_route_calc u_xy_next (
        .cur       (next_coord),
        .dest      (rec.dest),
        .local_idx (rec.local_idx),
        .port      (next_port)
    );

    // packet leaves here, or never gets routed
    assign lk_port = (is_local || rec.dest_err) ? '0 : next_port;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            destport   <= '0;
            lkdestport <= '0;
            dest_err   <= 1'b0;
        end else begin
            out_valid  <= rec.valid;
            destport   <= rec.valid ? rec.port : '0;    // zeros when idle
            lkdestport <= rec.valid ? lk_port : '0;
            dest_err   <= rec.valid & rec.dest_err;
        end
    end

endmodule

//--- design/mesh_endp_decode.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module mesh_endp_decode (
    input  noc_pkg::endp_addr_t  addr,
    output noc_pkg::mesh_coord_t coord,
    output logic [`MESH_LW-1:0]  local_idx,
    output logic                 err
);

    logic x_bad;
    logic y_bad;
    logic l_bad;

    assign coord.x   = addr.x;
    assign coord.y   = addr.y;
    assign local_idx = addr.local_idx;

    // field widths cover the next power of two, so the
    // mesh size itself has to be checked
    assign x_bad = int'(addr.x) >= `MESH_NX;
    assign y_bad = int'(addr.y) >= `MESH_NY;
    assign l_bad = int'(addr.local_idx) >= `MESH_NL;

    assign err = x_bad | y_bad | l_bad;

endmodule

//--- design/mesh_route_unit.sv
`timescale 1ns/100ps

module mesh_route_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  noc_pkg::route_req_t   req,
    output logic                  out_valid,
    output noc_pkg::port_onehot_t destport,
    output noc_pkg::port_onehot_t lkdestport,
    output logic                  dest_err
);

    noc_pkg::stage1_rec_t s1_rec;       // conventional route and decoded fields

    // decode and conventional XY
    route_compute_stage u_stage1 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .req      (req),
        .rec      (s1_rec)
    );

    // look-ahead XY at the next router
    look_ahead_stage u_stage2 (
        .clk        (clk),
        .rst        (rst),
        .rec        (s1_rec),
        .out_valid  (out_valid),
        .destport   (destport),
        .lkdestport (lkdestport),
        .dest_err   (dest_err)
    );

endmodule

//--- design/next_router_select.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module next_router_select (
    input  noc_pkg::mesh_coord_t  cur,
    input  noc_pkg::port_onehot_t port,
    output noc_pkg::mesh_coord_t  next,
    output logic                  is_local
);

    noc_pkg::mesh_coord_t nbr [4];      // indexed by mesh port position

    // XY never leaves the mesh, so no edge wrap handling
    always_comb begin
        nbr[`PORT_EAST]    = cur;
        nbr[`PORT_EAST].x  = cur.x + 1'b1;
        nbr[`PORT_NORTH]   = cur;
        nbr[`PORT_NORTH].y = cur.y + 1'b1;
        nbr[`PORT_WEST]    = cur;
        nbr[`PORT_WEST].x  = cur.x - 1'b1;
        nbr[`PORT_SOUTH]   = cur;
        nbr[`PORT_SOUTH].y = cur.y - 1'b1;
    end

    // one-hot and-or mux
    always_comb begin
        next = '0;
        for (int i = 0; i < 4; i++) begin
            next |= nbr[i] & {$bits(noc_pkg::mesh_coord_t){port[i]}};
        end
    end

    assign is_local = ~|port[3:0];      // local port or no port at all

endmodule

//--- design/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// mesh geometry
`define MESH_NX 4
`define MESH_NY 4
`define MESH_NL 2                   // endpoints per router

// address field widths
`define MESH_XW 2
`define MESH_YW 2
`define MESH_LW 1

`define MESH_P (4 + `MESH_NL)       // four mesh ports plus the locals

// bit positions in a one-hot port word
`define PORT_EAST   0
`define PORT_NORTH  1
`define PORT_WEST   2
`define PORT_SOUTH  3
`define PORT_LOCAL0 4               // local n at PORT_LOCAL0 + n

`endif

//--- design/noc_pkg.sv
`include "noc_params.svh"

package noc_pkg;

    typedef struct packed {
        logic [`MESH_YW-1:0] y;
        logic [`MESH_XW-1:0] x;
    } router_addr_t;

    typedef struct packed {
        logic [`MESH_LW-1:0] local_idx;
        logic [`MESH_YW-1:0] y;
        logic [`MESH_XW-1:0] x;
    } endp_addr_t;

    typedef struct packed {
        logic [`MESH_YW-1:0] y;
        logic [`MESH_XW-1:0] x;
    } mesh_coord_t;

    typedef logic [`MESH_P-1:0] port_onehot_t;     // zero means no port

    // header as it arrives at the top level
    typedef struct packed {
        router_addr_t cur;
        endp_addr_t   dest;
    } route_req_t;

    typedef struct packed {
        logic                valid;
        logic                dest_err;
        mesh_coord_t         cur;
        mesh_coord_t         dest;
        logic [`MESH_LW-1:0] local_idx;
        port_onehot_t        port;               // conventional route
    } stage1_rec_t;

endpackage

//--- design/route_compute_stage.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module route_compute_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  noc_pkg::route_req_t  req,
    output noc_pkg::stage1_rec_t rec
);

    noc_pkg::mesh_coord_t  cur_coord;
    noc_pkg::mesh_coord_t  dest_coord;
    logic [`MESH_LW-1:0]   local_idx;
    logic                  dest_err;
    noc_pkg::port_onehot_t xy_port;
    noc_pkg::stage1_rec_t  rec_d;

    assign cur_coord.x = req.cur.x;
    assign cur_coord.y = req.cur.y;

    mesh_endp_decode u_decode (
        .addr      (req.dest),
        .coord     (dest_coord),
        .local_idx (local_idx),
        .err       (dest_err)
    );

    xy_route_calc u_xy (
        .cur       (cur_coord),
        .dest      (dest_coord),
        .local_idx (local_idx),
        .port      (xy_port)
    );

    always_comb begin
        rec_d.valid     = in_valid;
        rec_d.dest_err  = dest_err;
        rec_d.cur       = cur_coord;
        rec_d.dest      = dest_coord;
        rec_d.local_idx = local_idx;
        rec_d.port      = dest_err ? '0 : xy_port;  // bad address routes nowhere
    end

    always_ff @(posedge clk) begin
        rec <= rec_d;
        if (rst) begin
            rec.valid <= 1'b0;      // drop any header in flight
        end
    end

endmodule

//--- design/xy_route_calc.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module xy_route_calc (
    input  noc_pkg::mesh_coord_t  cur,
    input  noc_pkg::mesh_coord_t  dest,
    input  logic [`MESH_LW-1:0]   local_idx,
    output noc_pkg::port_onehot_t port
);

    logic x_gt;
    logic x_lt;
    logic y_gt;
    logic y_lt;

    assign x_gt = dest.x > cur.x;
    assign x_lt = dest.x < cur.x;
    assign y_gt = dest.y > cur.y;
    assign y_lt = dest.y < cur.y;

    always_comb begin
        port = '0;
        if (x_gt) begin
            port[`PORT_EAST] = 1'b1;         // finish x first
        end else if (x_lt) begin
            port[`PORT_WEST] = 1'b1;
        end else if (y_gt) begin
            port[`PORT_NORTH] = 1'b1;
        end else if (y_lt) begin
            port[`PORT_SOUTH] = 1'b1;
        end else begin
            // arrived so take the endpoint port
            for (int n = 0; n < `MESH_NL; n++) begin
                if (int'(local_idx) == n) begin
                    port[`PORT_LOCAL0 + n] = 1'b1;
                end
            end
        end
    end

endmodule

//--- tests/mesh_route_checker.sv
`timescale 1ns/100ps

module mesh_route_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_valid,
    input logic                  out_valid,
    input noc_pkg::port_onehot_t destport,
    input noc_pkg::port_onehot_t lkdestport,
    input logic                  dest_err
);

    int fail_cnt = 0;

    // every header comes out after exactly two cycles
    a_latency: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##2 out_valid)
    else begin
        fail_cnt++;
        $error("out_valid missing two cycles after in_valid");
    end

    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, 2))
    else begin
        fail_cnt++;
        $error("out_valid without a header two cycles earlier");
    end

    a_dest_onehot: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !dest_err) |-> $onehot(destport))
    else begin
        fail_cnt++;
        $error("destport is not one-hot on a valid result");
    end

    a_lk_onehot0: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $onehot0(lkdestport))
    else begin
        fail_cnt++;
        $error("lkdestport has more than one bit set");
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !out_valid |-> (destport == '0 && lkdestport == '0 && !dest_err))
    else begin
        fail_cnt++;
        $error("outputs active while out_valid is low");
    end

    // both stages clear on the same edge, the stage one valid shows a cycle later
    a_reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> (!out_valid && !dest_err && destport == '0 && lkdestport == '0))
    else begin
        fail_cnt++;
        $error("outputs not cleared after reset");
    end

    a_reset_drain: assert property (@(posedge clk)
        $past(rst, 2) |-> !out_valid)
    else begin
        fail_cnt++;
        $error("out_valid raised before a header passed the pipeline");
    end

endmodule

bind mesh_route_unit mesh_route_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .destport   (destport),
    .lkdestport (lkdestport),
    .dest_err   (dest_err)
);

//--- tests/mesh_route_unit_tb.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module mesh_route_unit_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_RANDOM  = 300;
    localparam int MAX_HEADERS = 400;   // random plus directed with margin
    localparam int WATCHDOG_NS = MAX_HEADERS * 2 * CLK_PERIOD * 3;

    typedef struct packed {
        logic                  valid;
        logic                  dest_err;
        noc_pkg::port_onehot_t destport;
        noc_pkg::port_onehot_t lkdestport;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    noc_pkg::route_req_t   req;
    logic                  out_valid;
    noc_pkg::port_onehot_t destport;
    noc_pkg::port_onehot_t lkdestport;
    logic                  dest_err;

    expect_t     exp_new;                // two-entry expected queue
    expect_t     exp_head;               // lines up with out_valid
    int          errors = 0;
    int          checked = 0;
    int          sent = 0;
    logic [31:0] rng_state = 32'h1b1ef1d3;

    mesh_route_unit DUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .req        (req),
        .out_valid  (out_valid),
        .destport   (destport),
        .lkdestport (lkdestport),
        .dest_err   (dest_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // XY decision from integer coordinates
    function automatic noc_pkg::port_onehot_t xy_ref(input int cx, input int cy,
                                                     input int dx, input int dy,
                                                     input int dl);
        noc_pkg::port_onehot_t p;
        p = '0;
        if (dx > cx)
            p[`PORT_EAST] = 1'b1;
        else if (dx < cx)
            p[`PORT_WEST] = 1'b1;
        else if (dy > cy)
            p[`PORT_NORTH] = 1'b1;
        else if (dy < cy)
            p[`PORT_SOUTH] = 1'b1;
        else if (dl < `MESH_NL)
            p[`PORT_LOCAL0 + dl] = 1'b1;
        return p;
    endfunction

    function automatic expect_t expect_for(input noc_pkg::route_req_t r);
        expect_t e;
        int      cx, cy, dx, dy, dl, nx, ny;
        cx = int'(r.cur.x);
        cy = int'(r.cur.y);
        dx = int'(r.dest.x);
        dy = int'(r.dest.y);
        dl = int'(r.dest.local_idx);
        e = '0;
        e.valid    = 1'b1;
        e.dest_err = (dx >= `MESH_NX) || (dy >= `MESH_NY) || (dl >= `MESH_NL);
        if (!e.dest_err) begin
            e.destport = xy_ref(cx, cy, dx, dy, dl);
            nx = cx;
            ny = cy;
            if (e.destport[`PORT_EAST])  nx = cx + 1;
            if (e.destport[`PORT_WEST])  nx = cx - 1;
            if (e.destport[`PORT_NORTH]) ny = cy + 1;
            if (e.destport[`PORT_SOUTH]) ny = cy - 1;
            if (e.destport[3:0] != '0)
                e.lkdestport = xy_ref(nx, ny, dx, dy, dl);
        end
        return e;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            exp_new  <= '0;
            exp_head <= '0;
        end else begin
            exp_new  <= in_valid ? expect_for(req) : '0;
            exp_head <= exp_new;
            if (out_valid)
                checked <= checked + 1;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid == exp_head.valid)
    else begin
        errors++;
        $display("FAIL t=%0t out_valid expected %b got %b",
                 $time, $sampled(exp_head.valid), $sampled(out_valid));
    end

    a_destport: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> destport == exp_head.destport)
    else begin
        errors++;
        $display("FAIL t=%0t destport expected %b got %b",
                 $time, $sampled(exp_head.destport), $sampled(destport));
    end

    a_lkdestport: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> lkdestport == exp_head.lkdestport)
    else begin
        errors++;
        $display("FAIL t=%0t lkdestport expected %b got %b",
                 $time, $sampled(exp_head.lkdestport), $sampled(lkdestport));
    end

    a_dest_err: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> dest_err == exp_head.dest_err)
    else begin
        errors++;
        $display("FAIL t=%0t dest_err expected %b got %b",
                 $time, $sampled(exp_head.dest_err), $sampled(dest_err));
    end

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic send_header(input int cx, input int cy, input int dx,
                               input int dy, input int dl);
        in_valid          = 1'b1;
        req.cur.x         = cx[`MESH_XW-1:0];
        req.cur.y         = cy[`MESH_YW-1:0];
        req.dest.x        = dx[`MESH_XW-1:0];
        req.dest.y        = dy[`MESH_YW-1:0];
        req.dest.local_idx = dl[`MESH_LW-1:0];
        sent++;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_directed;
        send_header(0, 0, 3, 3, 0);     // east from a corner
        send_header(3, 3, 0, 0, 1);     // west from the opposite corner
        send_header(0, 0, 0, 3, 1);     // north
        send_header(3, 3, 3, 0, 0);     // south
        send_header(3, 0, 3, 0, 0);     // local 0 with no look-ahead
        send_header(0, 3, 0, 3, 1);     // local 1
        idle_cycles(2);
        send_header(2, 0, 3, 0, 0);     // neighbor is the edge router and destination
        send_header(3, 0, 0, 3, 1);
        send_header(0, 3, 3, 0, 0);
        send_header(1, 1, 1, 3, 0);
        send_header(2, 2, 2, 2, 1);
        send_header(0, 0, 3, 1, 0);
        idle_cycles(3);
    endtask

    task automatic run_random;
        int cx, cy;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            cx = int'(rng_state[7:0]) % `MESH_NX;    // router stays on the mesh
            cy = int'(rng_state[15:8]) % `MESH_NY;
            send_header(cx, cy, int'(rng_state[17:16]), int'(rng_state[19:18]),
                        int'(rng_state[20]));
            if (rng_state[23:21] < 3'd3)
                idle_cycles(1 + int'(rng_state[25:24]));
        end
        idle_cycles(1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        req      = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(2);
        run_directed();
        run_random();
        idle_cycles(4);                 // drain the 2-cycle pipeline
        if (checked != sent) begin
            errors++;
            $display("sent %0d headers but saw %0d results", sent, checked);
        end
        $display("headers %0d, value errors %0d, checker errors %0d",
                 sent, errors, DUT.u_checker.fail_cnt);
        if (errors == 0 && DUT.u_checker.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
